//--- logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  // encoded as {funct7[5], funct3}.
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111,
    alu_sub  = 4'b1000,
    alu_sra  = 4'b1101
  } alu_op_e;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
  } inst_u;

endpackage

`default_nettype wire

//--- logic/rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
  input  wire                     clk,
  input  wire                     rst,
  input  wire  [4:0]              raddr1_i,
  input  wire  [4:0]              raddr2_i,
  input  wire                     wr_en_i,
  input  wire  [4:0]              wr_addr_i,
  input  wire  [rv_pkg::xlen-1:0] wr_data_i,
  output logic [rv_pkg::xlen-1:0] rdata1_o,
  output logic [rv_pkg::xlen-1:0] rdata2_o
);

  logic [rv_pkg::xlen-1:0] regs [1:31]; // x0 has no storage.

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && (wr_addr_i != 5'd0)) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

//--- logic/rv_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module rv_fetch #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     next_pc_valid_i,
  input  wire  [rv_pkg::xlen-1:0] next_pc_i,
  input  wire                     decode_ready_i,
  input  wire  [31:0]             imem_data_i,
  output logic                    fetch_valid_o,
  output logic [31:0]             fetch_inst_o,
  output logic [rv_pkg::xlen-1:0] fetch_pc_o,
  output logic [rv_pkg::xlen-1:0] imem_addr_o
);

  logic [rv_pkg::xlen-1:0] pc_q;
  logic                    start_q; // the reset pc is known but not fetched yet.

  // a redirect is fetched in the same cycle it arrives.
  assign imem_addr_o = next_pc_valid_i ? next_pc_i : pc_q;
  assign fetch_pc_o  = pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q          <= reset_pc;
      start_q       <= 1'b1;
      fetch_valid_o <= 1'b0;
    end else begin
      if (fetch_valid_o && decode_ready_i) begin
        fetch_valid_o <= 1'b0;
      end
      if (next_pc_valid_i || start_q) begin
        pc_q          <= imem_addr_o;
        start_q       <= 1'b0;
        fetch_valid_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (next_pc_valid_i || start_q) begin
      fetch_inst_o <= imem_data_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/rv_decode.sv
`timescale 1ns/1ns
`default_nettype none

module rv_decode (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     prev_valid_i,
  input  wire  [31:0]             inst_i,
  input  wire  [rv_pkg::xlen-1:0] pc_i,
  input  wire  [rv_pkg::xlen-1:0] rdata1_i,
  input  wire  [rv_pkg::xlen-1:0] rdata2_i,
  input  wire                     next_ready_i,
  output logic                    valid_o,
  output logic                    ready_o,
  output logic [4:0]              rs1_o,
  output logic [4:0]              rs2_o,
  output logic [4:0]              rd_o,
  output rv_pkg::alu_op_e         alu_op_o,
  output logic [rv_pkg::xlen-1:0] op1_o,
  output logic [rv_pkg::xlen-1:0] op2_o,
  output logic [rv_pkg::xlen-1:0] op_j_o,
  output logic [rv_pkg::xlen-1:0] imm_o,
  output logic [2:0]              funct3_o,
  output logic                    wb_en_o,
  output logic                    jump_en_o,
  output logic                    branch_en_o,
  output logic                    illegal_o
);

  rv_pkg::inst_u           inst_q;
  logic                    busy;
  logic                    legal;
  logic [rv_pkg::xlen-1:0] imm_i;
  logic [rv_pkg::xlen-1:0] imm_b;
  logic [rv_pkg::xlen-1:0] imm_u;
  logic [rv_pkg::xlen-1:0] imm_j;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
    end else if (prev_valid_i && ready_o) begin
      busy <= 1'b1;
    end else if (valid_o && next_ready_i) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (prev_valid_i && ready_o) begin
      inst_q <= inst_i;
    end
  end

  // an illegal word is never handed on, so busy stays set and the core stops.
  assign ready_o   = !busy;
  assign valid_o   = busy && legal;
  assign illegal_o = busy && !legal;

  assign rs1_o    = inst_q.r_fmt.rs1;
  assign rs2_o    = inst_q.r_fmt.rs2;
  assign funct3_o = inst_q.r_fmt.funct3;

  assign imm_i = {{20{inst_q.i_fmt.imm_11_0[11]}}, inst_q.i_fmt.imm_11_0};
  assign imm_b = {{19{inst_q.b_fmt.imm_12}}, inst_q.b_fmt.imm_12, inst_q.b_fmt.imm_11,
                  inst_q.b_fmt.imm_10_5, inst_q.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {inst_q.u_fmt.imm_31_12, 12'b0};
  assign imm_j = {{11{inst_q.j_fmt.imm_20}}, inst_q.j_fmt.imm_20, inst_q.j_fmt.imm_19_12,
                  inst_q.j_fmt.imm_11, inst_q.j_fmt.imm_10_1, 1'b0};

  always_comb begin
    legal       = 1'b1;
    rd_o        = inst_q.r_fmt.rd;
    alu_op_o    = rv_pkg::alu_add;
    op1_o       = '0;
    op2_o       = '0;
    op_j_o      = '0;
    imm_o       = '0;
    wb_en_o     = 1'b0;
    jump_en_o   = 1'b0;
    branch_en_o = 1'b0;
    case (inst_q.r_fmt.opcode)
      rv_pkg::op_lui: begin
        imm_o   = imm_u;
        op2_o   = imm_u;
        wb_en_o = 1'b1;
      end
      rv_pkg::op_auipc: begin
        imm_o   = imm_u;
        op1_o   = pc_i;
        op2_o   = imm_u;
        wb_en_o = 1'b1;
      end
      rv_pkg::op_jal: begin
        imm_o     = imm_j;
        op1_o     = pc_i;
        op2_o     = 'd4; // link address.
        op_j_o    = pc_i;
        wb_en_o   = 1'b1;
        jump_en_o = 1'b1;
      end
      rv_pkg::op_jalr: begin
        imm_o     = imm_i;
        op1_o     = pc_i;
        op2_o     = 'd4;
        op_j_o    = rdata1_i;
        wb_en_o   = 1'b1;
        jump_en_o = 1'b1;
      end
      rv_pkg::op_branch: begin
        rd_o        = '0;
        imm_o       = imm_b;
        op1_o       = rdata1_i;
        op2_o       = rdata2_i;
        op_j_o      = pc_i;
        branch_en_o = 1'b1;
      end
      rv_pkg::op_imm: begin
        // only srai reads bit 30 of the word; the rest of the immediate is an operand.
        alu_op_o = rv_pkg::alu_op_e'({(inst_q.r_fmt.funct3[1:0] == 2'b01) &&
                                      inst_q.r_fmt.funct7[5], inst_q.r_fmt.funct3});
        imm_o    = imm_i;
        op1_o    = rdata1_i;
        op2_o    = imm_i;
        wb_en_o  = 1'b1;
      end
      rv_pkg::op_reg: begin
        alu_op_o = rv_pkg::alu_op_e'({inst_q.r_fmt.funct7[5], inst_q.r_fmt.funct3});
        op1_o    = rdata1_i;
        op2_o    = rdata2_i;
        wb_en_o  = 1'b1;
      end
      default: begin
        legal = 1'b0;
        rd_o  = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/rv_execute.sv
`timescale 1ns/1ns
`default_nettype none

module rv_execute (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     valid_i,
  input  rv_pkg::alu_op_e         alu_op_i,
  input  wire  [rv_pkg::xlen-1:0] op1_i,
  input  wire  [rv_pkg::xlen-1:0] op2_i,
  input  wire  [rv_pkg::xlen-1:0] op_j_i,
  input  wire  [rv_pkg::xlen-1:0] imm_i,
  input  wire  [2:0]              funct3_i,
  input  wire  [4:0]              rd_i,
  input  wire                     wb_en_i,
  input  wire                     jump_en_i,
  input  wire                     branch_en_i,
  input  wire  [rv_pkg::xlen-1:0] pc_i,
  input  wire                     ready_i,
  output logic                    valid_o,
  output logic                    ready_o,
  output logic [rv_pkg::xlen-1:0] alu_res_o,
  output logic [4:0]              rd_o,
  output logic                    wb_en_o,
  output logic                    taken_o,
  output logic [rv_pkg::xlen-1:0] target_o,
  output logic [rv_pkg::xlen-1:0] pc_o
);

  logic [rv_pkg::xlen-1:0] alu_res;
  logic [4:0]              shamt;
  logic                    lt_s;
  logic                    lt_u;
  logic                    cmp;

  assign shamt = op2_i[4:0];
  assign lt_s  = $signed(op1_i) < $signed(op2_i);
  assign lt_u  = op1_i < op2_i;

  always_comb begin
    case (alu_op_i)
      rv_pkg::alu_add:  alu_res = op1_i + op2_i;
      rv_pkg::alu_sub:  alu_res = op1_i - op2_i;
      rv_pkg::alu_sll:  alu_res = op1_i << shamt;
      rv_pkg::alu_slt:  alu_res = {{(rv_pkg::xlen-1){1'b0}}, lt_s};
      rv_pkg::alu_sltu: alu_res = {{(rv_pkg::xlen-1){1'b0}}, lt_u};
      rv_pkg::alu_xor:  alu_res = op1_i ^ op2_i;
      rv_pkg::alu_srl:  alu_res = op1_i >> shamt;
      rv_pkg::alu_sra:  alu_res = $signed(op1_i) >>> shamt;
      rv_pkg::alu_or:   alu_res = op1_i | op2_i;
      rv_pkg::alu_and:  alu_res = op1_i & op2_i;
      default:          alu_res = '0;
    endcase
  end

  always_comb begin
    case (funct3_i)
      3'b000:  cmp = op1_i == op2_i;
      3'b001:  cmp = op1_i != op2_i;
      3'b100:  cmp = lt_s;
      3'b101:  cmp = !lt_s;
      3'b110:  cmp = lt_u;
      3'b111:  cmp = !lt_u;
      default: cmp = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_o <= 1'b0;
      ready_o <= 1'b1;
    end else if (valid_i && ready_o) begin
      valid_o <= 1'b1;
      ready_o <= 1'b0;
    end else if (valid_o && ready_i) begin
      valid_o <= 1'b0;
      ready_o <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      alu_res_o <= alu_res;
      rd_o      <= rd_i;
      wb_en_o   <= wb_en_i;
      taken_o   <= jump_en_i || (branch_en_i && cmp);
      // jal and branch targets are already even.
      target_o  <= (op_j_i + imm_i) & ~{{(rv_pkg::xlen-1){1'b0}}, 1'b1};
      pc_o      <= pc_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/rv_result.sv
`timescale 1ns/1ns
`default_nettype none

module rv_result (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     valid_i,
  input  wire  [rv_pkg::xlen-1:0] alu_res_i,
  input  wire  [4:0]              rd_i,
  input  wire                     wb_en_i,
  input  wire                     taken_i,
  input  wire  [rv_pkg::xlen-1:0] target_i,
  input  wire  [rv_pkg::xlen-1:0] pc_i,
  output logic                    ready_o,
  output logic                    wr_en_o,
  output logic [4:0]              wr_addr_o,
  output logic [rv_pkg::xlen-1:0] wr_data_o,
  output logic                    next_pc_valid_o,
  output logic [rv_pkg::xlen-1:0] next_pc_o,
  output logic                    retire_valid_o,
  output logic [rv_pkg::xlen-1:0] retire_pc_o,
  output logic                    retire_wen_o,
  output logic [4:0]              retire_rd_o,
  output logic [rv_pkg::xlen-1:0] retire_data_o
);

  logic                    busy;
  logic [rv_pkg::xlen-1:0] alu_res_q;
  logic [4:0]              rd_q;
  logic                    wb_en_q;
  logic                    taken_q;
  logic [rv_pkg::xlen-1:0] target_q;
  logic [rv_pkg::xlen-1:0] pc_q;

  assign ready_o   = !busy;
  assign wr_en_o   = busy && wb_en_q; // write lands on the same edge as the retire pulse.
  assign wr_addr_o = rd_q;
  assign wr_data_o = alu_res_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy            <= 1'b0;
      retire_valid_o  <= 1'b0;
      next_pc_valid_o <= 1'b0;
    end else begin
      busy            <= valid_i && !busy;
      retire_valid_o  <= busy;
      next_pc_valid_o <= busy;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && !busy) begin
      alu_res_q <= alu_res_i;
      rd_q      <= rd_i;
      wb_en_q   <= wb_en_i;
      taken_q   <= taken_i;
      target_q  <= target_i;
      pc_q      <= pc_i;
    end
    if (busy) begin
      next_pc_o     <= taken_q ? target_q : pc_q + 'd4;
      retire_pc_o   <= pc_q;
      retire_wen_o  <= wb_en_q;
      retire_rd_o   <= rd_q;
      retire_data_o <= alu_res_q;
    end
  end

endmodule

`default_nettype wire

//--- logic/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire  [31:0]             imem_data_i,
  output logic [rv_pkg::xlen-1:0] imem_addr_o,
  output logic                    retire_valid_o,
  output logic [rv_pkg::xlen-1:0] retire_pc_o,
  output logic                    retire_wen_o,
  output logic [4:0]              retire_rd_o,
  output logic [rv_pkg::xlen-1:0] retire_data_o,
  output logic                    illegal_o
);

  logic                    fetch_valid;
  logic [31:0]             fetch_inst;
  logic [rv_pkg::xlen-1:0] fetch_pc;
  logic                    decode_ready;
  logic                    decode_valid;
  logic [4:0]              rs1;
  logic [4:0]              rs2;
  logic [4:0]              decode_rd;
  rv_pkg::alu_op_e         alu_op;
  logic [rv_pkg::xlen-1:0] op1;
  logic [rv_pkg::xlen-1:0] op2;
  logic [rv_pkg::xlen-1:0] op_j;
  logic [rv_pkg::xlen-1:0] imm;
  logic [2:0]              funct3;
  logic                    decode_wb_en;
  logic                    jump_en;
  logic                    branch_en;
  logic [rv_pkg::xlen-1:0] rdata1;
  logic [rv_pkg::xlen-1:0] rdata2;
  logic                    execute_ready;
  logic                    execute_valid;
  logic [rv_pkg::xlen-1:0] alu_res;
  logic [4:0]              execute_rd;
  logic                    execute_wb_en;
  logic                    taken;
  logic [rv_pkg::xlen-1:0] target;
  logic [rv_pkg::xlen-1:0] execute_pc;
  logic                    result_ready;
  logic                    wr_en;
  logic [4:0]              wr_addr;
  logic [rv_pkg::xlen-1:0] wr_data;
  logic                    next_pc_valid;
  logic [rv_pkg::xlen-1:0] next_pc;

  rv_fetch #(.reset_pc(reset_pc)) u_fetch (
    .clk(clk), .rst(rst),
    .next_pc_valid_i(next_pc_valid), .next_pc_i(next_pc),
    .decode_ready_i(decode_ready), .imem_data_i(imem_data_i),
    .fetch_valid_o(fetch_valid), .fetch_inst_o(fetch_inst),
    .fetch_pc_o(fetch_pc), .imem_addr_o(imem_addr_o)
  );

  rv_decode u_decode (
    .clk(clk), .rst(rst),
    .prev_valid_i(fetch_valid), .inst_i(fetch_inst), .pc_i(fetch_pc),
    .rdata1_i(rdata1), .rdata2_i(rdata2), .next_ready_i(execute_ready),
    .valid_o(decode_valid), .ready_o(decode_ready),
    .rs1_o(rs1), .rs2_o(rs2), .rd_o(decode_rd), .alu_op_o(alu_op),
    .op1_o(op1), .op2_o(op2), .op_j_o(op_j), .imm_o(imm), .funct3_o(funct3),
    .wb_en_o(decode_wb_en), .jump_en_o(jump_en), .branch_en_o(branch_en),
    .illegal_o(illegal_o)
  );

  // fetch holds the pc until the redirect, so execute takes it from there.
  rv_execute u_execute (
    .clk(clk), .rst(rst),
    .valid_i(decode_valid), .alu_op_i(alu_op), .op1_i(op1), .op2_i(op2),
    .op_j_i(op_j), .imm_i(imm), .funct3_i(funct3), .rd_i(decode_rd),
    .wb_en_i(decode_wb_en), .jump_en_i(jump_en), .branch_en_i(branch_en),
    .pc_i(fetch_pc), .ready_i(result_ready),
    .valid_o(execute_valid), .ready_o(execute_ready), .alu_res_o(alu_res),
    .rd_o(execute_rd), .wb_en_o(execute_wb_en), .taken_o(taken),
    .target_o(target), .pc_o(execute_pc)
  );

  rv_result u_result (
    .clk(clk), .rst(rst),
    .valid_i(execute_valid), .alu_res_i(alu_res), .rd_i(execute_rd),
    .wb_en_i(execute_wb_en), .taken_i(taken), .target_i(target), .pc_i(execute_pc),
    .ready_o(result_ready), .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
    .next_pc_valid_o(next_pc_valid), .next_pc_o(next_pc),
    .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
    .retire_wen_o(retire_wen_o), .retire_rd_o(retire_rd_o),
    .retire_data_o(retire_data_o)
  );

  rv_regfile u_regfile (
    .clk(clk), .rst(rst),
    .raddr1_i(rs1), .raddr2_i(rs2),
    .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
    .rdata1_o(rdata1), .rdata2_o(rdata2)
  );

endmodule

`default_nettype wire

//--- dv/rv_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb;

  logic        clk;
  logic        rst;
  logic [31:0] imem_data;
  logic [31:0] imem_addr;
  logic        retire_valid;
  logic [31:0] retire_pc;
  logic        retire_wen;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;
  logic        illegal;

  logic [31:0] prog [$];
  logic [31:0] ref_regs [32];
  logic [31:0] base_pc;
  logic [31:0] ref_pc;
  logic [31:0] ill_addr;
  logic        halted = 1'b0;
  int          cycles = 0;
  int          limit;
  int          last_retire = -1;
  int          retired = 0;
  int          check_errors = 0;
  int          other_errors = 0;

  rv_core #(.reset_pc(32'h0000_0200)) u_rv_core (
    .clk(clk), .rst(rst), .imem_data_i(imem_data), .imem_addr_o(imem_addr),
    .retire_valid_o(retire_valid), .retire_pc_o(retire_pc), .retire_wen_o(retire_wen),
    .retire_rd_o(retire_rd), .retire_data_o(retire_data), .illegal_o(illegal)
  );

  function automatic logic [31:0] reg_op_word(input logic [6:0] funct7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd);
    rv_pkg::inst_u w;
    w.r_fmt = {funct7, rs2, rs1, funct3, rd, rv_pkg::op_reg};
    return w;
  endfunction

  function automatic logic [31:0] imm_word(input logic [6:0] opcode, input logic [4:0] rd,
      input logic [2:0] funct3, input logic [4:0] rs1, input logic [11:0] imm);
    rv_pkg::inst_u w;
    w.i_fmt = {imm, rs1, funct3, rd, opcode};
    return w;
  endfunction

  function automatic logic [31:0] upper_word(input logic [6:0] opcode, input logic [4:0] rd,
      input logic [19:0] imm);
    rv_pkg::inst_u w;
    w.u_fmt = {imm, rd, opcode};
    return w;
  endfunction

  function automatic logic [31:0] branch_word(input logic [2:0] funct3, input logic [4:0] rs1,
      input logic [4:0] rs2, input int off);
    rv_pkg::inst_u w;
    logic [12:0]   o;
    o = off[12:0];
    w.b_fmt = {o[12], o[10:5], rs2, rs1, funct3, o[4:1], o[11], rv_pkg::op_branch};
    return w;
  endfunction

  function automatic logic [31:0] jal_word(input logic [4:0] rd, input int off);
    rv_pkg::inst_u w;
    logic [20:0]   o;
    o = off[20:0];
    w.j_fmt = {o[20], o[10:1], o[11], o[19:12], rd, rv_pkg::op_jal};
    return w;
  endfunction

  function automatic logic [31:0] program_word(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - base_pc) >> 2;
    if (addr[1:0] != 2'b00 || addr < base_pc || idx >= prog.size()) begin
      return 32'h0; // opcode zero is not part of the core.
    end
    return prog[idx];
  endfunction

  function automatic logic [31:0] expected_alu(input logic [2:0] f3, input logic alt,
      input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'b000: r = alt ? a - b : a + b;
      3'b001: r = a << b[4:0];
      3'b010: r = {31'b0, $signed(a) < $signed(b)};
      3'b011: r = {31'b0, a < b};
      3'b100: r = a ^ b;
      3'b101: begin
        if (alt) r = $signed(a) >>> b[4:0];
        else r = a >> b[4:0];
      end
      3'b110: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_holds(input logic [2:0] f3, input logic [31:0] a,
      input logic [31:0] b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      3'b111: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      check_errors++;
    end
  endtask

  function automatic logic [31:0] next_addr();
    return base_pc + 32'(4 * prog.size());
  endfunction

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  // a taken compare skips one increment of x6, the other compare falls into it.
  task automatic branch_both_ways(input logic [2:0] f3, input logic [4:0] t1,
      input logic [4:0] t2, input logic [4:0] n1, input logic [4:0] n2);
    emit(branch_word(f3, t1, t2, 8));
    emit(imm_word(rv_pkg::op_imm, 5'd6, 3'b000, 5'd6, 12'd1));
    emit(branch_word(f3, n1, n2, 8));
    emit(imm_word(rv_pkg::op_imm, 5'd6, 3'b000, 5'd6, 12'd1));
  endtask

  task automatic build_program();
    logic [2:0] f3;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       alt;
    emit(upper_word(rv_pkg::op_lui, 5'd1, 20'h80000));
    emit(imm_word(rv_pkg::op_imm, 5'd2, 3'b000, 5'd0, 12'hffb)); // x2 is -5.
    emit(imm_word(rv_pkg::op_imm, 5'd3, 3'b000, 5'd0, 12'd100));
    emit(upper_word(rv_pkg::op_lui, 5'd4, 20'h12345));
    emit(imm_word(rv_pkg::op_imm, 5'd4, 3'b000, 5'd4, 12'h678));
    emit(upper_word(rv_pkg::op_auipc, 5'd5, 20'h00001));
    emit(imm_word(rv_pkg::op_imm, 5'd0, 3'b000, 5'd0, 12'd7));
    emit(reg_op_word(7'h00, 5'd3, 5'd0, 3'b000, 5'd6)); // reads x0 after the write above.
    emit(reg_op_word(7'h20, 5'd3, 5'd2, 3'b000, 5'd7));
    emit(imm_word(rv_pkg::op_imm, 5'd7, 3'b101, 5'd7, {7'h20, 5'd2}));
    emit(imm_word(rv_pkg::op_imm, 5'd8, 3'b101, 5'd2, {7'h00, 5'd28}));
    emit(reg_op_word(7'h20, 5'd3, 5'd1, 3'b101, 5'd9));
    emit(reg_op_word(7'h00, 5'd3, 5'd1, 3'b101, 5'd10));
    emit(imm_word(rv_pkg::op_imm, 5'd11, 3'b001, 5'd3, {7'h00, 5'd3}));
    emit(reg_op_word(7'h00, 5'd3, 5'd2, 3'b010, 5'd12));
    emit(reg_op_word(7'h00, 5'd3, 5'd2, 3'b011, 5'd13));
    branch_both_ways(3'b000, 5'd3, 5'd3, 5'd2, 5'd3);
    branch_both_ways(3'b001, 5'd2, 5'd3, 5'd3, 5'd3);
    branch_both_ways(3'b100, 5'd2, 5'd3, 5'd3, 5'd2);
    branch_both_ways(3'b101, 5'd3, 5'd2, 5'd2, 5'd3);
    branch_both_ways(3'b110, 5'd3, 5'd2, 5'd2, 5'd3);
    branch_both_ways(3'b111, 5'd2, 5'd3, 5'd3, 5'd2);
    emit(jal_word(5'd14, 8));
    emit(imm_word(rv_pkg::op_imm, 5'd6, 3'b000, 5'd6, 12'd1));
    emit(upper_word(rv_pkg::op_auipc, 5'd15, 20'h0));
    emit(imm_word(rv_pkg::op_jalr, 5'd14, 3'b000, 5'd15, 12'd13)); // odd sum, bit 0 drops.
    emit(imm_word(rv_pkg::op_imm, 5'd6, 3'b000, 5'd6, 12'd1));
    for (int k = 0; k < 40; k++) begin
      f3  = 3'($urandom_range(7));
      rd  = 5'($urandom_range(15));
      rs1 = 5'($urandom_range(15));
      rs2 = 5'($urandom_range(15));
      alt = ($urandom_range(1) == 1) && (f3 == 3'b000 || f3 == 3'b101);
      if ($urandom_range(1) == 0) begin
        emit(reg_op_word({1'b0, alt, 5'b0}, rs2, rs1, f3, rd));
      end else if (f3 == 3'b001) begin
        emit(imm_word(rv_pkg::op_imm, rd, f3, rs1, {7'b0, rs2}));
      end else if (f3 == 3'b101) begin
        emit(imm_word(rv_pkg::op_imm, rd, f3, rs1, {1'b0, alt, 5'b0, rs2}));
      end else begin
        emit(imm_word(rv_pkg::op_imm, rd, f3, rs1, 12'($urandom())));
      end
    end
    // countdown loop around a skipped load, then a jump back onto that load.
    emit(imm_word(rv_pkg::op_imm, 5'd11, 3'b000, 5'd0, 12'd2));
    emit(branch_word(3'b000, 5'd0, 5'd0, 8));
    ill_addr = next_addr();
    emit(imm_word(7'b0000011, 5'd1, 3'b010, 5'd0, 12'd0));
    emit(imm_word(rv_pkg::op_imm, 5'd11, 3'b000, 5'd11, 12'hfff));
    emit(branch_word(3'b001, 5'd11, 5'd0, -12));
    emit(upper_word(rv_pkg::op_auipc, 5'd12, 20'h0));
    emit(imm_word(rv_pkg::op_jalr, 5'd0, 3'b000, 5'd12, 12'hff4));
  endtask

  task automatic model_retire();
    rv_pkg::inst_u w;
    logic [31:0]   a;
    logic [31:0]   b;
    logic [31:0]   i_imm;
    logic [31:0]   data;
    logic [31:0]   next;
    logic          wen;
    w     = program_word(ref_pc);
    a     = ref_regs[w.r_fmt.rs1];
    b     = ref_regs[w.r_fmt.rs2];
    i_imm = {{20{w.i_fmt.imm_11_0[11]}}, w.i_fmt.imm_11_0};
    data  = '0;
    next  = ref_pc + 32'd4;
    wen   = 1'b1;
    case (w.r_fmt.opcode)
      rv_pkg::op_lui:   data = {w.u_fmt.imm_31_12, 12'b0};
      rv_pkg::op_auipc: data = ref_pc + {w.u_fmt.imm_31_12, 12'b0};
      rv_pkg::op_jal: begin
        data = ref_pc + 32'd4;
        next = ref_pc + {{11{w.j_fmt.imm_20}}, w.j_fmt.imm_20, w.j_fmt.imm_19_12,
                         w.j_fmt.imm_11, w.j_fmt.imm_10_1, 1'b0};
      end
      rv_pkg::op_jalr: begin
        data = ref_pc + 32'd4;
        next = (a + i_imm) & 32'hffff_fffe;
      end
      rv_pkg::op_branch: begin
        wen = 1'b0;
        if (branch_holds(w.b_fmt.funct3, a, b)) begin
          next = ref_pc + {{19{w.b_fmt.imm_12}}, w.b_fmt.imm_12, w.b_fmt.imm_11,
                           w.b_fmt.imm_10_5, w.b_fmt.imm_4_1, 1'b0};
        end
      end
      rv_pkg::op_imm: begin
        data = expected_alu(w.r_fmt.funct3, (w.r_fmt.funct3 == 3'b101) && w.r_fmt.funct7[5],
                            a, i_imm);
      end
      rv_pkg::op_reg: data = expected_alu(w.r_fmt.funct3, w.r_fmt.funct7[5], a, b);
      default: begin
        $display("an instruction with an unsupported opcode retired at pc %h", ref_pc);
        other_errors++;
      end
    endcase
    if (retired == 0) check_value("retire_pc_o (first retire)", retire_pc, base_pc);
    check_value("retire_pc_o", retire_pc, ref_pc);
    check_value("retire_wen_o", retire_wen, wen);
    if (wen) begin
      check_value("retire_rd_o", retire_rd, w.r_fmt.rd);
      check_value("retire_data_o", retire_data, data);
      if (w.r_fmt.rd != 5'd0) ref_regs[w.r_fmt.rd] = data;
    end
    if (last_retire >= 0) check_value("retire_valid_o interval", cycles - last_retire, 5);
    last_retire = cycles;
    retired++;
    ref_pc = next;
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    if (!rst) cycles <= cycles + 1;
  end

  always @(negedge clk) begin
    imem_data <= program_word(imem_addr); // the address only moves on rising edges.
  end

  always @(negedge clk) begin
    if (!rst && retire_valid) begin
      if (halted) begin
        $display("a retire pulse at %0t ns came after illegal_o was set", $time);
        other_errors++;
      end else begin
        model_retire();
      end
    end
  end

  initial begin
    rst       = 1'b1;
    imem_data = '0;
    void'($urandom(69352));
    base_pc = u_rv_core.reset_pc;
    ref_pc  = base_pc;
    for (int r = 0; r < 32; r++) ref_regs[r] = '0;
    build_program();
    limit = 5 * prog.size() + 50;
    repeat (2) @(negedge clk);
    check_value("retire_valid_o", retire_valid, 1'b0);
    check_value("illegal_o", illegal, 1'b0);
    rst = 1'b0;
    while (!illegal && cycles < limit) @(negedge clk);
    if (!illegal) begin
      $display("timeout after %0d cycles, illegal_o never rose", limit);
      other_errors++;
    end else begin
      halted = 1'b1;
      check_value("imem_addr_o", imem_addr, ill_addr); // fetch still holds the illegal word.
      repeat (10) begin
        @(negedge clk);
        check_value("illegal_o", illegal, 1'b1);
      end
    end
    @(posedge clk);
    $display("retired %0d instructions, %0d check errors, %0d other errors",
             retired, check_errors, other_errors);
    if (check_errors == 0 && other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_core.f
logic/rv_pkg.sv
logic/rv_regfile.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_result.sv
logic/rv_core.sv
dv/rv_core_tb.sv
